// ==== bus_arbiter.sv ====
// purely combinational; a CPU raising dWEN together with dREN is taken as an eviction
`timescale 1ns/10ps

module bus_arbiter import coherence_pkg::*; #(
    parameter int CPUS = 4,
    localparam int CPU_W = (CPUS > 1) ? $clog2(CPUS) : 1
) (
    input  logic [CPUS-1:0]  dREN,
    input  logic [CPUS-1:0]  dWEN,
    input  logic [CPUS-1:0]  ccwrite,
    output req_kind_t        req_kind,
    output logic [CPU_W-1:0] req_cpu
);

    // per-kind request masks, each CPU lands in at most one
    logic [CPUS-1:0] evict_v, readx_v, read_v, inv_v;

    assign evict_v = dWEN;
    assign readx_v = dREN & ccwrite & ~dWEN;
    assign read_v  = dREN & ~ccwrite & ~dWEN;
    assign inv_v   = ccwrite & ~dREN & ~dWEN;

    // highest set bit wins
    function automatic logic [CPU_W-1:0] top_cpu(input logic [CPUS-1:0] mask);
        logic [CPU_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < CPUS; i++) begin
            if (mask[i]) idx = CPU_W'(i);
        end
        return idx;
    endfunction

    // kind-level choice: evict > read-x > read > inv
    always_comb begin
        req_kind = REQ_NONE;
        req_cpu  = '0;
        if (|evict_v) begin
            req_kind = REQ_EVICT;
            req_cpu  = top_cpu(evict_v);
        end else if (|readx_v) begin
            req_kind = REQ_READ_X;
            req_cpu  = top_cpu(readx_v);
        end else if (|read_v) begin
            req_kind = REQ_READ;
            req_cpu  = top_cpu(read_v);
        end else if (|inv_v) begin
            req_kind = REQ_INV;
            req_cpu  = top_cpu(inv_v);
        end
    end

endmodule

// ==== bus_ctrl.sv ====
// one request in flight; requester must hold daddr/dstore until its dwait bit drops
`timescale 1ns/10ps

module bus_ctrl import coherence_pkg::*; #(
    parameter int CPUS = 4,
    parameter int BLOCK_SIZE = 2,
    localparam int CPU_W = (CPUS > 1) ? $clog2(CPUS) : 1
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  req_kind_t                             req_kind,
    input  logic [CPU_W-1:0]                      req_cpu,
    input  word_t [CPUS-1:0]                      daddr,
    input  word_t [CPUS-1:0][BLOCK_SIZE-1:0]      dstore,
    input  logic                                  all_done,
    input  logic                                  any_hit,
    input  logic                                  none_present,
    input  logic                                  supplier_dirty,
    input  logic [CPU_W-1:0]                      supplier,
    input  l2_state_t                             l2_state,
    input  word_t [BLOCK_SIZE-1:0]                l2_rdata,
    output logic [CPUS-1:0]                       dwait,
    output logic [CPUS-1:0]                       ccwait,
    output logic [CPUS-1:0]                       ccinv,
    output logic [CPUS-1:0]                       ccexclusive,
    output word_t [CPUS-1:0][BLOCK_SIZE-1:0]      dload,
    output logic                                  snoop_start,
    output logic                                  snoop_capture,
    output logic [CPU_W-1:0]                      requester,
    output logic                                  l2_ren,
    output logic                                  l2_wen,
    output word_t                                 l2_addr,
    output word_t [BLOCK_SIZE-1:0]                l2_wdata
);

    bus_state_t      state, nstate;
    logic            excl;       // fill as E, nobody else has it
    logic            wb_needed;  // supplier was M, copy back after S transfer
    logic [CPUS-1:0] others;
    word_t           blk_addr;

    assign others   = ~(CPUS'(1) << requester);
    assign blk_addr = daddr[requester] & BLOCK_OFFSET_MASK;

    // next state
    always_comb begin
        nstate = state;
        case (state)
            IDLE: begin
                case (req_kind)
                    REQ_EVICT:  nstate = GRANT_EVICT;
                    REQ_READ_X: nstate = GRANT_RX;
                    REQ_READ:   nstate = GRANT_R;
                    REQ_INV:    nstate = GRANT_INV;
                    default:    nstate = IDLE;
                endcase
            end
            GRANT_R:        nstate = SNOOP_R;
            GRANT_RX:       nstate = SNOOP_RX;
            GRANT_EVICT:    nstate = WRITEBACK;
            GRANT_INV:      nstate = SNOOP_INV;
            SNOOP_R:        if (all_done) nstate = any_hit ? TRANSFER_R : READ_L2;
            SNOOP_RX:       if (all_done) nstate = any_hit ? TRANSFER_RX : READ_L2;
            SNOOP_INV:      if (all_done) nstate = INVALIDATE;
            TRANSFER_R:     nstate = TRANSFER_R_FIN;
            TRANSFER_RX:    nstate = BUS_TO_L1;
            TRANSFER_R_FIN: nstate = wb_needed ? WRITEBACK : IDLE;
            READ_L2:        if (l2_state == L2_ACCESS) nstate = BUS_TO_L1;
            BUS_TO_L1:      nstate = IDLE;
            WRITEBACK:      if (l2_state == L2_ACCESS) nstate = IDLE;  // evict / M copy-back done
            INVALIDATE:     nstate = IDLE;
            default:        nstate = IDLE;
        endcase
    end

    // outputs, decoded from state only
    always_comb begin
        dwait         = '1;
        ccwait        = '0;
        ccinv         = '0;
        ccexclusive   = '0;
        snoop_start   = 1'b0;
        snoop_capture = 1'b0;
        l2_ren        = 1'b0;
        l2_wen        = 1'b0;
        case (state)
            GRANT_R, GRANT_RX, GRANT_INV: snoop_start = 1'b1;
            GRANT_EVICT: dwait[requester] = 1'b0;  // release early, L2 write runs after
            SNOOP_R: begin
                ccwait        = others;
                snoop_capture = all_done;
            end
            SNOOP_RX, SNOOP_INV: begin
                ccwait        = others;
                ccinv         = others;  // BusRdX / BusUpgr kill other copies
                snoop_capture = all_done;
            end
            TRANSFER_R, TRANSFER_RX: ccwait = others;  // supplier keeps dstore up
            TRANSFER_R_FIN, BUS_TO_L1: begin
                dwait[requester]       = 1'b0;
                ccexclusive[requester] = excl;
            end
            READ_L2:    l2_ren = 1'b1;
            WRITEBACK:  l2_wen = 1'b1;
            INVALIDATE: dwait[requester] = 1'b0;
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            requester <= '0;
            excl      <= 1'b0;
            wb_needed <= 1'b0;
        end else begin
            state <= nstate;
            case (state)
                IDLE: begin
                    if (req_kind != REQ_NONE) requester <= req_cpu;
                    excl      <= 1'b0;
                    wb_needed <= 1'b0;
                end
                TRANSFER_R: begin
                    excl      <= none_present;
                    wb_needed <= supplier_dirty;
                end
                TRANSFER_RX, READ_L2: excl <= none_present;  // captured at end of snoop
                default: ;
            endcase
        end
    end

    // block and address payload
    always_ff @(posedge CLK) begin
        case (state)
            GRANT_EVICT: begin
                l2_addr  <= blk_addr;
                l2_wdata <= dstore[requester];
            end
            GRANT_R, GRANT_RX: l2_addr <= blk_addr;  // miss fill or later copy-back
            TRANSFER_R: begin
                dload[requester] <= dstore[supplier];
                l2_wdata         <= dstore[supplier];
            end
            TRANSFER_RX: dload[requester] <= dstore[supplier];  // cache to cache
            READ_L2: begin
                if (l2_state == L2_ACCESS) dload[requester] <= l2_rdata;
            end
            default: ;
        endcase
    end

endmodule

// ==== coherence_bus.f ====
coherence_pkg.sv
bus_arbiter.sv
snoop_unit.sv
bus_ctrl.sv
l2_store.sv
coherence_bus.sv
coherence_bus_properties.sv
tb_coherence_bus.sv

// ==== coherence_bus.sv ====
// bus side only; L1 caches sit outside and follow the dwait / ccwait handshake
`timescale 1ns/10ps

module coherence_bus import coherence_pkg::*; #(
    parameter int CPUS = 4,
    parameter int BLOCK_SIZE = 2,
    parameter int L2_BLOCKS = 16,
    parameter int L2_LATENCY = 3
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [CPUS-1:0]                   dREN,
    input  logic [CPUS-1:0]                   dWEN,
    input  logic [CPUS-1:0]                   ccwrite,
    input  word_t [CPUS-1:0]                  daddr,
    input  word_t [CPUS-1:0][BLOCK_SIZE-1:0]  dstore,
    input  logic [CPUS-1:0]                   ccsnoopdone,
    input  logic [CPUS-1:0]                   ccsnoophit,
    input  logic [CPUS-1:0]                   ccIsPresent,
    input  logic [CPUS-1:0]                   ccdirty,
    output logic [CPUS-1:0]                   dwait,
    output word_t [CPUS-1:0][BLOCK_SIZE-1:0]  dload,
    output word_t [CPUS-1:0]                  ccsnoopaddr,
    output logic [CPUS-1:0]                   ccwait,
    output logic [CPUS-1:0]                   ccinv,
    output logic [CPUS-1:0]                   ccexclusive
);

    localparam int CPU_W = (CPUS > 1) ? $clog2(CPUS) : 1;

    req_kind_t              req_kind;
    logic [CPU_W-1:0]       req_cpu, requester, supplier;
    logic                   snoop_start, snoop_capture;
    logic                   all_done, any_hit, none_present, supplier_dirty;
    logic                   l2_ren, l2_wen;
    word_t                  l2_addr;
    word_t [BLOCK_SIZE-1:0] l2_wdata, l2_rdata;
    l2_state_t              l2_state;

    bus_arbiter #(.CPUS(CPUS)) arb (
        .dREN(dREN), .dWEN(dWEN), .ccwrite(ccwrite),
        .req_kind(req_kind), .req_cpu(req_cpu)
    );

    snoop_unit #(.CPUS(CPUS)) snoop (
        .CLK(CLK), .nRST(nRST), .daddr(daddr), .requester(requester),
        .snoop_start(snoop_start), .snoop_capture(snoop_capture),
        .ccsnoopdone(ccsnoopdone), .ccsnoophit(ccsnoophit),
        .ccIsPresent(ccIsPresent), .ccdirty(ccdirty), .ccsnoopaddr(ccsnoopaddr),
        .all_done(all_done), .any_hit(any_hit), .none_present(none_present),
        .supplier_dirty(supplier_dirty), .supplier(supplier)
    );

    bus_ctrl #(.CPUS(CPUS), .BLOCK_SIZE(BLOCK_SIZE)) ctrl (
        .CLK(CLK), .nRST(nRST), .req_kind(req_kind), .req_cpu(req_cpu),
        .daddr(daddr), .dstore(dstore), .all_done(all_done), .any_hit(any_hit),
        .none_present(none_present), .supplier_dirty(supplier_dirty),
        .supplier(supplier), .l2_state(l2_state), .l2_rdata(l2_rdata),
        .dwait(dwait), .ccwait(ccwait), .ccinv(ccinv), .ccexclusive(ccexclusive),
        .dload(dload), .snoop_start(snoop_start), .snoop_capture(snoop_capture),
        .requester(requester), .l2_ren(l2_ren), .l2_wen(l2_wen),
        .l2_addr(l2_addr), .l2_wdata(l2_wdata)
    );

    l2_store #(.BLOCK_SIZE(BLOCK_SIZE), .L2_BLOCKS(L2_BLOCKS), .L2_LATENCY(L2_LATENCY)) l2 (
        .CLK(CLK), .nRST(nRST), .l2_ren(l2_ren), .l2_wen(l2_wen),
        .l2_addr(l2_addr), .l2_wdata(l2_wdata),
        .l2_rdata(l2_rdata), .l2_state(l2_state)
    );

endmodule

// ==== coherence_bus_properties.sv ====
// bound into coherence_bus; checks handshake and invalidation rules only, not data
`timescale 1ns/10ps

module coherence_bus_properties #(
    parameter int CPUS = 4,
    localparam int CPU_W = (CPUS > 1) ? $clog2(CPUS) : 1
) (
    input logic             CLK,
    input logic             nRST,
    input logic [CPUS-1:0]  dwait,
    input logic [CPUS-1:0]  ccwait,
    input logic [CPUS-1:0]  ccinv,
    input logic [CPUS-1:0]  ccexclusive,
    input logic [CPU_W-1:0] requester,
    input logic             l2_ren,
    input logic             l2_wen
);

    int fail_cnt = 0;  // failed assertions so far

    single_release: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(~dwait))
        else begin fail_cnt++; $error("two CPUs released in one cycle"); end

    // only snooped non-requesters may be told to invalidate
    inv_to_snooped: assert property (@(posedge CLK) disable iff (!nRST)
        (ccinv & ~(ccwait & ~(CPUS'(1) << requester))) == '0)
        else begin fail_cnt++; $error("ccinv outside a snoop or to the requester"); end

    l2_one_op: assert property (@(posedge CLK) disable iff (!nRST) !(l2_ren && l2_wen))
        else begin fail_cnt++; $error("L2 read and write requested together"); end

    excl_on_release: assert property (@(posedge CLK) disable iff (!nRST)
        (ccexclusive & dwait) == '0)
        else begin fail_cnt++; $error("ccexclusive high without dwait release"); end

endmodule

bind coherence_bus coherence_bus_properties #(.CPUS(CPUS)) props (
    .CLK(CLK), .nRST(nRST), .dwait(dwait), .ccwait(ccwait), .ccinv(ccinv),
    .ccexclusive(ccexclusive), .requester(requester), .l2_ren(l2_ren), .l2_wen(l2_wen)
);

// ==== coherence_pkg.sv ====
// shared types for the MESI bus; block alignment mask assumes 2-word blocks of 32-bit words (8 bytes)
package coherence_pkg;

    // one data/address word
    typedef logic [31:0] word_t;

    // clears byte and word offset, low 3 bits
    localparam word_t BLOCK_OFFSET_MASK = ~word_t'(3'b111);

    // request kind, listed in arbitration priority after none
    typedef enum logic [2:0] {
        REQ_NONE,
        REQ_EVICT,   // dWEN
        REQ_READ_X,  // dREN with ccwrite
        REQ_READ,    // dREN alone
        REQ_INV      // ccwrite alone, upgrade from S
    } req_kind_t;

    // bus controller FSM
    typedef enum logic [3:0] {
        IDLE,
        GRANT_R,
        GRANT_RX,
        GRANT_EVICT,
        GRANT_INV,
        SNOOP_R,
        SNOOP_RX,
        SNOOP_INV,
        TRANSFER_R,
        TRANSFER_RX,
        TRANSFER_R_FIN,
        READ_L2,
        BUS_TO_L1,
        WRITEBACK,
        INVALIDATE
    } bus_state_t;

    // L2 access status seen by the bus
    typedef enum logic [1:0] {
        L2_FREE,
        L2_BUSY,     // latency cycles running
        L2_ACCESS    // one cycle, data valid / write commits
    } l2_state_t;

endpackage

// ==== l2_store.sv ====
// fixed-latency block store, L2_LATENCY >= 1, L2_BLOCKS a power of two >= 2; request held until L2_ACCESS
`timescale 1ns/10ps

module l2_store import coherence_pkg::*; #(
    parameter int BLOCK_SIZE = 2,
    parameter int L2_BLOCKS = 16,
    parameter int L2_LATENCY = 3
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   l2_ren,
    input  logic                   l2_wen,
    input  word_t                  l2_addr,
    input  word_t [BLOCK_SIZE-1:0] l2_wdata,
    output word_t [BLOCK_SIZE-1:0] l2_rdata,
    output l2_state_t              l2_state
);

    localparam int OFFSET_W = 3;  // matches BLOCK_OFFSET_MASK
    localparam int IDX_W = $clog2(L2_BLOCKS);
    localparam int CNT_W = $clog2(L2_LATENCY + 1);

    word_t [BLOCK_SIZE-1:0] mem [L2_BLOCKS];
    l2_state_t              st;
    logic [CNT_W-1:0]       busy_cnt;  // busy cycles already spent
    logic [IDX_W-1:0]       idx;
    logic                   req;

    assign idx      = l2_addr[OFFSET_W +: IDX_W];
    assign req      = l2_ren | l2_wen;
    assign l2_rdata = mem[idx];
    // first request cycle already counts as busy
    assign l2_state = (st == L2_FREE && req) ? L2_BUSY : st;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            st       <= L2_FREE;
            busy_cnt <= '0;
            for (int i = 0; i < L2_BLOCKS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (st)
                L2_FREE: begin
                    if (req) begin
                        busy_cnt <= CNT_W'(1);
                        st       <= (L2_LATENCY == 1) ? L2_ACCESS : L2_BUSY;
                    end
                end
                L2_BUSY: begin
                    if (busy_cnt == CNT_W'(L2_LATENCY - 1)) st <= L2_ACCESS;
                    else busy_cnt <= busy_cnt + 1'b1;
                end
                L2_ACCESS: begin
                    if (l2_wen) mem[idx] <= l2_wdata;  // commit at end of access
                    st <= L2_FREE;
                end
                default: st <= L2_FREE;
            endcase
        end
    end

endmodule

// ==== snoop_unit.sv ====
// snoop responses are sampled only on snoop_capture; caches must hold them until ccwait drops
`timescale 1ns/10ps

module snoop_unit import coherence_pkg::*; #(
    parameter int CPUS = 4,
    localparam int CPU_W = (CPUS > 1) ? $clog2(CPUS) : 1
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  word_t [CPUS-1:0]      daddr,
    input  logic [CPU_W-1:0]      requester,
    input  logic                  snoop_start,
    input  logic                  snoop_capture,
    input  logic [CPUS-1:0]       ccsnoopdone,
    input  logic [CPUS-1:0]       ccsnoophit,
    input  logic [CPUS-1:0]       ccIsPresent,
    input  logic [CPUS-1:0]       ccdirty,
    output word_t [CPUS-1:0]      ccsnoopaddr,
    output logic                  all_done,
    output logic                  any_hit,
    output logic                  none_present,
    output logic                  supplier_dirty,
    output logic [CPU_W-1:0]      supplier
);

    logic [CPUS-1:0]  req_mask;  // one-hot requester
    logic [CPUS-1:0]  others;    // everyone being snooped
    logic [CPU_W-1:0] hit_cpu;

    assign req_mask = CPUS'(1) << requester;
    assign others   = ~req_mask;
    assign all_done = &(ccsnoopdone | req_mask);  // requester never answers itself
    assign any_hit  = |(ccsnoophit & others);

    // highest hitting non-requester supplies
    always_comb begin
        hit_cpu = '0;
        for (int i = 0; i < CPUS; i++) begin
            if (ccsnoophit[i] && others[i]) hit_cpu = CPU_W'(i);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ccsnoopaddr    <= '0;
            supplier       <= '0;
            none_present   <= 1'b0;
            supplier_dirty <= 1'b0;
        end else begin
            if (snoop_start) begin
                for (int i = 0; i < CPUS; i++) begin
                    if (others[i]) ccsnoopaddr[i] <= daddr[requester] & BLOCK_OFFSET_MASK;
                end
            end
            if (snoop_capture) begin
                supplier       <= hit_cpu;
                none_present   <= ~|(ccIsPresent & others);  // drives E on fill
                supplier_dirty <= ccdirty[hit_cpu] & any_hit;
            end
        end
    end

endmodule

// ==== tb_coherence_bus.sv ====
// 4 CPUs, caches modelled as full per-block tables over blocks 0..15; requests legal per MESI
`timescale 1ns/10ps

module tb_coherence_bus import coherence_pkg::*; ();

    localparam int CPUS = 4;
    localparam int BLOCK_SIZE = 2;
    localparam int L2_BLOCKS = 16;
    localparam int L2_LATENCY = 3;
    localparam int LIMIT = 60 * (L2_LATENCY + 12);  // cycles for 60 requests

    typedef word_t [BLOCK_SIZE-1:0] block_t;

    logic CLK, nRST;
    logic [CPUS-1:0] dREN, dWEN, ccwrite, ccsnoopdone, ccsnoophit, ccIsPresent, ccdirty;
    logic [CPUS-1:0] dwait, ccwait, ccinv, ccexclusive;
    word_t [CPUS-1:0] daddr, ccsnoopaddr;
    word_t [CPUS-1:0][BLOCK_SIZE-1:0] dstore, dload;

    logic   held_v [CPUS][L2_BLOCKS];  // cache table, valid
    logic   held_d [CPUS][L2_BLOCKS];  // dirty (M)
    block_t held_data [CPUS][L2_BLOCKS];
    block_t shadow [L2_BLOCKS];        // expected L2 content
    bit        pend_v [CPUS];
    req_kind_t pend_kind [CPUS];
    int        pend_blk [CPUS];
    int        delay [CPUS];
    logic [CPUS-1:0] inv_seen;
    int errors = 0;
    int l2_cycles, cycles = 0;

    coherence_bus #(.CPUS(CPUS), .BLOCK_SIZE(BLOCK_SIZE), .L2_BLOCKS(L2_BLOCKS),
        .L2_LATENCY(L2_LATENCY)) UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // snoop responder, answers each ccwait after 0..3 cycles
    always @(negedge CLK) begin : responder
        int b, want;
        word_t exp_addr;
        for (int i = 0; i < CPUS; i++) begin
            if (!ccwait[i]) begin
                ccsnoopdone[i] = 1'b0;
                ccsnoophit[i]  = 1'b0;
                ccIsPresent[i] = 1'b0;
                ccdirty[i]     = 1'b0;
                delay[i]       = $urandom % 4;
            end else if (!ccsnoopdone[i]) begin
                if (delay[i] == 0) begin
                    want = next_in_order();  // request now on the bus
                    exp_addr = (want >= 0) ? word_t'(pend_blk[want] * 8) : '1;
                    assert (ccsnoopaddr[i] == exp_addr) else
                        log_mismatch($sformatf("cpu %0d ccsnoopaddr %h expected %h",
                            i, ccsnoopaddr[i], exp_addr));
                    b = ccsnoopaddr[i][6:3];
                    ccsnoopdone[i] = 1'b1;
                    ccsnoophit[i]  = held_v[i][b];
                    ccIsPresent[i] = held_v[i][b];
                    ccdirty[i]     = held_v[i][b] && held_d[i][b];
                    dstore[i]      = held_data[i][b];  // supply data if hit
                end else delay[i]--;
            end
        end
    end

    always @(negedge CLK) begin
        inv_seen |= ccinv;
        if (UUT.l2_ren || UUT.l2_wen) l2_cycles++;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic block_t rand_block();
        block_t blk;
        for (int w = 0; w < BLOCK_SIZE; w++) blk[w] = $urandom;
        return blk;
    endfunction

    task automatic raise(input int cpu, input req_kind_t kind, input int blk);
        pend_v[cpu]    = 1'b1;
        pend_kind[cpu] = kind;
        pend_blk[cpu]  = blk;
        daddr[cpu]     = word_t'(blk * 8 + 4 * ($urandom % 2));  // any word of the block
        case (kind)
            REQ_EVICT: begin
                dWEN[cpu]   = 1'b1;
                dstore[cpu] = held_data[cpu][blk];
            end
            REQ_READ:   dREN[cpu] = 1'b1;
            REQ_READ_X: begin
                dREN[cpu]    = 1'b1;
                ccwrite[cpu] = 1'b1;
            end
            default:    ccwrite[cpu] = 1'b1;  // upgrade
        endcase
    endtask

    // priority: evict, read-x, read, inv; highest cpu first within a kind
    function automatic int next_in_order();
        req_kind_t order [4] = '{REQ_EVICT, REQ_READ_X, REQ_READ, REQ_INV};
        foreach (order[k]) begin
            for (int c = CPUS - 1; c >= 0; c--) begin
                if (pend_v[c] && pend_kind[c] == order[k]) return c;
            end
        end
        return -1;
    endfunction

    task automatic check_release(input int cpu, input bit single);
        int b, sup;
        block_t exp;
        bit exp_x, is_read;
        logic [CPUS-1:0] exp_inv;
        b = pend_blk[cpu];
        sup = -1;
        for (int j = 0; j < CPUS; j++) begin
            if (j != cpu && held_v[j][b]) sup = j;  // highest holder supplies
        end
        exp = (sup >= 0) ? held_data[sup][b] : shadow[b];
        is_read = pend_kind[cpu] inside {REQ_READ, REQ_READ_X};
        exp_x = is_read && sup < 0;
        if (is_read) begin
            assert (dload[cpu] == exp) else
                log_mismatch($sformatf("cpu %0d dload %h expected %h", cpu, dload[cpu], exp));
        end
        assert (ccexclusive[cpu] == exp_x) else
            log_mismatch($sformatf("cpu %0d ccexclusive %b expected %b",
                cpu, ccexclusive[cpu], exp_x));
        if (single) begin
            exp_inv = (pend_kind[cpu] inside {REQ_READ_X, REQ_INV}) ? ~(CPUS'(1) << cpu) : '0;
            assert (inv_seen == exp_inv) else
                log_mismatch($sformatf("ccinv seen %b expected %b", inv_seen, exp_inv));
            assert (pend_kind[cpu] != REQ_INV || l2_cycles == 0) else
                log_mismatch("invalidate touched the L2");
        end
        case (pend_kind[cpu])
            REQ_READ: begin
                if (sup >= 0 && held_d[sup][b]) begin
                    shadow[b]      = exp;  // copy-back after transfer
                    held_d[sup][b] = 1'b0;
                end
                held_v[cpu][b]    = 1'b1;
                held_d[cpu][b]    = 1'b0;
                held_data[cpu][b] = exp;
            end
            REQ_READ_X, REQ_INV: begin
                for (int j = 0; j < CPUS; j++) begin
                    held_v[j][b] = 1'b0;
                    held_d[j][b] = 1'b0;
                end
                held_v[cpu][b]    = 1'b1;
                held_d[cpu][b]    = 1'b1;
                held_data[cpu][b] = rand_block();  // cpu writes after ownership
            end
            default: begin
                shadow[b]      = held_data[cpu][b];
                held_v[cpu][b] = 1'b0;
                held_d[cpu][b] = 1'b0;
            end
        endcase
    endtask

    task automatic serve_all();
        int cpu, want, n;
        bit single;
        n = 0;
        foreach (pend_v[i]) n += pend_v[i];
        single = (n == 1);
        inv_seen = '0;
        l2_cycles = 0;
        while (n > 0) begin
            @(negedge CLK);
            if (dwait != '1) begin
                cpu = 0;
                for (int i = 0; i < CPUS; i++) if (!dwait[i]) cpu = i;
                want = next_in_order();
                assert (cpu == want) else
                    log_mismatch($sformatf("cpu %0d released, expected cpu %0d", cpu, want));
                if (pend_v[cpu]) check_release(cpu, single);
                dREN[cpu]    = 1'b0;
                dWEN[cpu]    = 1'b0;
                ccwrite[cpu] = 1'b0;
                pend_v[cpu]  = 1'b0;
                n--;
            end
        end
        @(negedge CLK);
        while (UUT.ctrl.state != IDLE) @(negedge CLK);  // pending write-back
    endtask

    task automatic one_request(input int cpu, input req_kind_t kind, input int blk);
        @(negedge CLK);
        raise(cpu, kind, blk);
        serve_all();
    endtask

    initial begin : stimulus
        int cpu, b;
        void'($urandom(55));
        nRST = 1'b0;
        {dREN, dWEN, ccwrite, ccsnoopdone, ccsnoophit, ccIsPresent, ccdirty} = '0;
        daddr = '0;
        dstore = '0;
        for (int c = 0; c < CPUS; c++) begin
            pend_v[c] = 1'b0;
            for (int k = 0; k < L2_BLOCKS; k++) begin
                held_v[c][k]    = 1'b0;
                held_d[c][k]    = 1'b0;
                held_data[c][k] = '0;
            end
        end
        foreach (shadow[k]) shadow[k] = '0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        one_request(0, REQ_READ_X, 3);  // miss, then evict and miss read
        one_request(0, REQ_EVICT, 3);
        one_request(1, REQ_READ, 3);
        one_request(2, REQ_READ_X, 5);  // dirty supplier cases
        one_request(1, REQ_READ, 5);
        held_v[1][5] = 1'b0;            // clean S copies dropped without bus traffic
        held_v[2][5] = 1'b0;
        one_request(3, REQ_READ, 5);    // miss, L2 must hold the copy-back
        one_request(0, REQ_READ_X, 5);
        one_request(0, REQ_EVICT, 5);
        one_request(3, REQ_READ, 5);
        one_request(2, REQ_READ, 3);    // shared, then upgrade
        one_request(1, REQ_INV, 3);
        one_request(2, REQ_READ, 10);
        one_request(3, REQ_READ_X, 11);
        @(negedge CLK);                 // four at once
        raise(0, REQ_READ, 8);
        raise(1, REQ_READ_X, 9);
        raise(2, REQ_INV, 10);
        raise(3, REQ_EVICT, 11);
        serve_all();
        @(negedge CLK);                 // same kind twice, index decides
        raise(0, REQ_READ_X, 12);
        raise(2, REQ_READ_X, 13);
        raise(3, REQ_READ, 14);
        serve_all();
        for (int r = 0; r < 40; r++) begin
            cpu = $urandom % CPUS;
            b = $urandom % 8;
            if (held_d[cpu][b]) one_request(cpu, REQ_EVICT, b);
            else if (held_v[cpu][b]) one_request(cpu, REQ_INV, b);
            else one_request(cpu, ($urandom % 2) ? REQ_READ : REQ_READ_X, b);
        end
        $display("errors: %0d, assertion failures: %0d", errors, UUT.props.fail_cnt);
        if (errors == 0 && UUT.props.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
